// ==== text_edit_pkg.sv ====
package text_edit_pkg;

    //////////////////////////////
    // Capacity and widths
    //////////////////////////////

    localparam int symbol_width = 7;
    localparam int symbol_count = 15;
    localparam int index_width  = $clog2(symbol_count);
    localparam int length_width = $clog2(symbol_count + 1);

    //////////////////////////////
    // Key codes
    //////////////////////////////

    typedef enum logic [1:0] {
        ctrl_none,
        ctrl_left,
        ctrl_right,
        ctrl_backspace
    } ctrl_code_t;

    typedef struct packed {
        logic                    ctrl;
        logic [symbol_width-1:0] symbol;
    } key_symbol_view_t;

    typedef struct packed {
        logic       ctrl;
        logic [4:0] spare;
        ctrl_code_t code;
    } key_control_view_t;

    // Same key word seen as a printable symbol or as a control code
    typedef union packed {
        key_symbol_view_t  sym;
        key_control_view_t ctl;
    } key_code_t;

    // Symbol of zero means no insert
    typedef struct packed {
        logic                    left;
        logic                    right;
        logic                    backspace;
        logic [symbol_width-1:0] symbol;
    } edit_cmd_t;

    typedef enum logic [1:0] {
        cell_hold,
        cell_insert,
        cell_remove
    } cell_op_t;

endpackage

// ==== key_decoder.sv ====
module key_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  text_edit_pkg::key_code_t key,
    input  logic                     key_valid,
    output logic                     key_ready,
    output text_edit_pkg::edit_cmd_t edit,
    input  logic                     input_ready
);
    import text_edit_pkg::*;

    edit_cmd_t decoded;

    // Printable symbol first, control code otherwise
    always_comb begin
        decoded = '0;
        if (!key.sym.ctrl && (key.sym.symbol != '0)) begin
            decoded.symbol = key.sym.symbol;
        end else begin
            case (key.ctl.code)
                ctrl_left: begin
                    decoded.left = 1'b1;
                end
                ctrl_right: begin
                    decoded.right = 1'b1;
                end
                ctrl_backspace: begin
                    decoded.backspace = 1'b1;
                end
                default: begin
                    decoded = '0;
                end
            endcase
        end
    end

    // Free again once the held edit has been cleared
    assign key_ready = (edit == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edit <= '0;
        end else if (!key_ready) begin
            if (input_ready) begin
                edit <= '0;
            end
        end else if (key_valid && (decoded != '0)) begin
            edit <= decoded;
        end
    end

endmodule

// ==== symbol_cell.sv ====
module symbol_cell (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  text_edit_pkg::cell_op_t                op,
    input  logic                                   at_or_above,
    input  logic [text_edit_pkg::symbol_width-1:0] below_data,
    input  logic [text_edit_pkg::symbol_width-1:0] above_data,
    input  logic                                   load_here,
    input  logic [text_edit_pkg::symbol_width-1:0] data_in,
    output logic [text_edit_pkg::symbol_width-1:0] data
);
    import text_edit_pkg::*;

    // Empty slots read as zero, so the slot after the text is always blank
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data <= '0;
        end else begin
            case (op)
                cell_insert: begin
                    if (load_here) begin
                        data <= data_in;
                    end else if (at_or_above) begin
                        // Make room by taking the lower neighbour
                        data <= below_data;
                    end
                end
                cell_remove: begin
                    if (at_or_above) begin
                        data <= above_data;
                    end
                end
                default: begin
                    data <= data;
                end
            endcase
        end
    end

endmodule

// ==== symbol_vector.sv ====
module symbol_vector (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  text_edit_pkg::cell_op_t                op,
    input  logic [text_edit_pkg::index_width-1:0]  index,
    input  logic [text_edit_pkg::symbol_width-1:0] data_in,
    input  logic                                   get,
    output logic [text_edit_pkg::symbol_width-1:0] data_out,
    output logic [text_edit_pkg::length_width-1:0] length,
    output logic                                   ready
);
    import text_edit_pkg::*;

    // Cell i sits at row[i + 1], both ends are fixed zeros
    logic [symbol_width-1:0] row [0:symbol_count + 1];
    logic                    shifted;

    assign row[0]                = '0;
    assign row[symbol_count + 1] = '0;

    //////////////////////////////
    // Cell row
    //////////////////////////////

    for (genvar i = 0; i < symbol_count; i++) begin : g_cell
        logic at_or_above;
        logic load_here;

        assign at_or_above = (index <= index_width'(i));
        assign load_here   = (index == index_width'(i));

        symbol_cell u_cell (
            .clk         (clk),
            .rst_n       (rst_n),
            .op          (op),
            .at_or_above (at_or_above),
            .below_data  (row[i]),
            .above_data  (row[i + 2]),
            .load_here   (load_here),
            .data_in     (data_in),
            .data        (row[i + 1])
        );
    end

    //////////////////////////////
    // Length and ready
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            length  <= '0;
            shifted <= 1'b0;
        end else begin
            shifted <= (op != cell_hold);
            case (op)
                cell_insert: begin
                    length <= length + length_width'(1);
                end
                cell_remove: begin
                    length <= length - length_width'(1);
                end
                default: begin
                    length <= length;
                end
            endcase
        end
    end

    // Low for the one cycle after a shift
    assign ready = !shifted;

    //////////////////////////////
    // Read port
    //////////////////////////////

    // An index of symbol_count lands on the upper zero end
    always_ff @(posedge clk) begin
        if (get) begin
            data_out <= row[int'(index) + 1];
        end
    end

endmodule

// ==== text_buffer.sv ====
module text_buffer (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  text_edit_pkg::edit_cmd_t               edit,
    output logic                                   input_ready,
    input  logic                                   iter_en,
    output logic [text_edit_pkg::symbol_width-1:0] iter_out,
    output logic                                   iter_out_valid,
    output logic                                   cursor_left,
    output logic                                   cursor_right
);
    import text_edit_pkg::*;

    typedef enum logic [1:0] {
        state_ready,
        state_handle,
        state_iter
    } state_t;

    state_t state;

    logic [length_width-1:0] cursor_index;
    logic [length_width-1:0] iter_index;
    logic                    inserted;

    cell_op_t                vec_op;
    logic [index_width-1:0]  vec_index;
    logic                    vec_get;
    logic [symbol_width-1:0] vec_data_out;
    logic [length_width-1:0] vec_length;
    logic                    vec_ready;

    logic has_edit;
    logic can_insert;
    logic can_remove;

    assign has_edit   = edit.left | edit.right | edit.backspace | (edit.symbol != '0);
    assign can_insert = (edit.symbol != '0) && (vec_length != length_width'(symbol_count));
    assign can_remove = edit.backspace && (cursor_index != '0);

    assign input_ready = (state == state_handle) && vec_ready;
    assign iter_out    = iter_out_valid ? vec_data_out : '0;

    symbol_vector u_vector (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (vec_op),
        .index    (vec_index),
        .data_in  (edit.symbol),
        .get      (vec_get),
        .data_out (vec_data_out),
        .length   (vec_length),
        .ready    (vec_ready)
    );

    //////////////////////////////
    // Vector commands
    //////////////////////////////

    always_comb begin
        vec_op    = cell_hold;
        vec_index = '0;
        vec_get   = 1'b0;
        case (state)
            state_ready: begin
                if (can_insert) begin
                    vec_op    = cell_insert;
                    vec_index = index_width'(cursor_index);
                end else if (can_remove) begin
                    vec_op    = cell_remove;
                    vec_index = index_width'(cursor_index - length_width'(1));
                end
            end
            state_iter: begin
                vec_index = index_width'(iter_index);
                vec_get   = iter_en;
            end
            default: begin
                vec_op = cell_hold;
            end
        endcase
    end

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= state_ready;
            cursor_index   <= '0;
            iter_index     <= '0;
            inserted       <= 1'b0;
            iter_out_valid <= 1'b0;
            cursor_left    <= 1'b0;
            cursor_right   <= 1'b0;
        end else begin
            iter_out_valid <= 1'b0;
            cursor_left    <= 1'b0;
            cursor_right   <= 1'b0;

            case (state)
                state_ready: begin
                    // Pending edits win over a new iteration pass
                    if (has_edit) begin
                        inserted <= can_insert;
                        state    <= state_handle;
                    end else if (iter_en) begin
                        state <= state_iter;
                    end
                end
                state_handle: begin
                    // Length has already moved when ready comes back
                    if (vec_ready) begin
                        if ((edit.left || edit.backspace) && (cursor_index != '0)) begin
                            cursor_index <= cursor_index - length_width'(1);
                        end else if (inserted ||
                                     (edit.right && (cursor_index != vec_length))) begin
                            cursor_index <= cursor_index + length_width'(1);
                        end
                        state <= state_ready;
                    end
                end
                state_iter: begin
                    if (iter_en) begin
                        iter_out_valid <= 1'b1;
                        cursor_left    <= (iter_index == cursor_index);
                        cursor_right   <= (cursor_index != '0) &&
                                          (iter_index == cursor_index - length_width'(1));
                        // Last output is the blank slot after the text
                        if (iter_index == vec_length) begin
                            iter_index <= '0;
                            state      <= state_ready;
                        end else begin
                            iter_index <= iter_index + length_width'(1);
                        end
                    end
                end
                default: begin
                    state <= state_ready;
                end
            endcase
        end
    end

endmodule

// ==== text_editor_top.sv ====
module text_editor_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  text_edit_pkg::key_code_t               key,
    input  logic                                   key_valid,
    output logic                                   key_ready,
    input  logic                                   iter_en,
    output logic [text_edit_pkg::symbol_width-1:0] iter_out,
    output logic                                   iter_out_valid,
    output logic                                   cursor_left,
    output logic                                   cursor_right
);
    import text_edit_pkg::*;

    // Decoded edit held until the buffer applies it
    edit_cmd_t edit;
    logic      input_ready;

    key_decoder u_key_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .key         (key),
        .key_valid   (key_valid),
        .key_ready   (key_ready),
        .edit        (edit),
        .input_ready (input_ready)
    );

    text_buffer u_text_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .edit           (edit),
        .input_ready    (input_ready),
        .iter_en        (iter_en),
        .iter_out       (iter_out),
        .iter_out_valid (iter_out_valid),
        .cursor_left    (cursor_left),
        .cursor_right   (cursor_right)
    );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for five clock cycles
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== tb_text_editor.sv ====
module tb_text_editor;
    timeunit 1ns;
    timeprecision 100ps;

    import text_edit_pkg::*;

    typedef struct packed {
        logic                    left;
        logic                    right;
        logic [symbol_width-1:0] symbol;
    } iter_sample_t;

    localparam int wait_limit = 64;

    logic                    clk;
    logic                    rst_n;
    key_code_t               key;
    logic                    key_valid;
    logic                    key_ready;
    logic                    iter_en;
    logic [symbol_width-1:0] iter_out;
    logic                    iter_out_valid;
    logic                    cursor_left;
    logic                    cursor_right;

    // Reference model of the text and the cursor
    logic [symbol_width-1:0] model_text [$];
    int                      cursor;
    iter_sample_t            samples [$];
    int                      checks;
    int                      errors;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    text_editor_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .key            (key),
        .key_valid      (key_valid),
        .key_ready      (key_ready),
        .iter_en        (iter_en),
        .iter_out       (iter_out),
        .iter_out_valid (iter_out_valid),
        .cursor_left    (cursor_left),
        .cursor_right   (cursor_right)
    );

    //////////////////////////////
    // Protocol assertions
    //////////////////////////////

    assert property (@(posedge clk) disable iff (!rst_n) !iter_en |=> !iter_out_valid)
        else begin
            errors++;
            $display("[ERROR] t=%0t iter_out_valid: got 1, expected 0 after iter_en low", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     (cursor_left || cursor_right) |-> iter_out_valid)
        else begin
            errors++;
            $display("[ERROR] t=%0t iter_out_valid: got 0, expected 1 with a cursor mark", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) (key_valid && key_ready) |=> !key_ready)
        else begin
            errors++;
            $display("[ERROR] t=%0t key_ready: got 1, expected 0 after a key strobe", $time);
        end

    // Output monitor, sampled away from the driving edge
    always @(negedge clk) begin
        if (rst_n && iter_out_valid) begin
            samples.push_back({cursor_left, cursor_right, iter_out});
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic compare_value(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    // Printable ASCII range
    function automatic logic [symbol_width-1:0] random_symbol();
        return symbol_width'($urandom_range(126, 32));
    endfunction

    function automatic key_code_t move_key();
        ctrl_code_t code;
        code = ($urandom_range(1, 0) == 1) ? ctrl_left : ctrl_right;
        return key_code_t'({1'b1, 5'b0, code});
    endfunction

    task automatic apply_to_model(input key_code_t k);
        if (!k.sym.ctrl && (k.sym.symbol != '0)) begin
            if (model_text.size() < symbol_count) begin
                model_text.insert(cursor, k.sym.symbol);
                cursor++;
            end
        end else if ((k.ctl.code == ctrl_left) && (cursor > 0)) begin
            cursor--;
        end else if ((k.ctl.code == ctrl_right) && (cursor < model_text.size())) begin
            cursor++;
        end else if ((k.ctl.code == ctrl_backspace) && (cursor > 0)) begin
            model_text.delete(cursor - 1);
            cursor--;
        end
    endtask

    task automatic send_key(input key_code_t k);
        int waited;
        waited = 0;
        while (!key_ready && (waited < wait_limit)) begin
            @(negedge clk);
            waited++;
        end
        if (!key_ready) begin
            errors++;
            $display("Timeout: key_ready stayed low before key %h", k);
        end
        @(posedge clk);
        key       <= k;
        key_valid <= 1'b1;
        @(posedge clk);
        key_valid <= 1'b0;
        // The held edit clears once the buffer has applied it
        waited = 0;
        @(negedge clk);
        while (!key_ready && (waited < wait_limit)) begin
            @(negedge clk);
            waited++;
        end
        if (key_ready) begin
            apply_to_model(k);
        end else begin
            errors++;
            $display("Timeout: key %h was never applied by the buffer", k);
        end
    endtask

    task automatic iterate_and_check(input int pause_after, input int pause_len);
        int expected;
        int enabled;
        int paused;
        int waited;
        int i;
        expected = model_text.size() + 1;
        enabled  = 0;
        paused   = 0;
        waited   = 0;
        samples.delete();
        @(posedge clk);
        iter_en <= 1'b1;
        // One enabled edge enters ITER, then one edge per output
        while ((enabled < expected + 1) && (waited < wait_limit)) begin
            @(posedge clk);
            waited++;
            if (iter_en) begin
                enabled++;
            end
            if ((enabled == pause_after) && (paused < pause_len)) begin
                iter_en <= 1'b0;
                paused++;
            end else begin
                iter_en <= (enabled < expected + 1);
            end
        end
        waited = 0;
        while ((samples.size() < expected) && (waited < wait_limit)) begin
            @(negedge clk);
            waited++;
        end
        // Extra outputs would show up within a few idle cycles
        repeat (3) @(negedge clk);
        compare_value("output count", samples.size(), expected);
        for (i = 0; (i < expected) && (i < samples.size()); i++) begin
            compare_value($sformatf("iter_out[%0d]", i), int'(samples[i].symbol),
                          (i < model_text.size()) ? int'(model_text[i]) : 0);
            compare_value($sformatf("cursor_left[%0d]", i), int'(samples[i].left),
                          int'(i == cursor));
            compare_value($sformatf("cursor_right[%0d]", i), int'(samples[i].right),
                          int'((cursor != 0) && (i == cursor - 1)));
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        int waited;
        void'($urandom(32'h7373_e93b));
        key       = '0;
        key_valid = 1'b0;
        iter_en   = 1'b0;
        cursor    = 0;
        checks    = 0;
        errors    = 0;
        waited    = 0;
        while (!rst_n && (waited < wait_limit)) begin
            @(negedge clk);
            waited++;
        end
        if (!rst_n) begin
            errors++;
            $display("Timeout: reset was never released");
        end
        @(negedge clk);

        // Reset state, then a single blank output from the empty buffer
        compare_value("key_ready", int'(key_ready), 1);
        compare_value("iter_out_valid", int'(iter_out_valid), 0);
        compare_value("cursor_left", int'(cursor_left), 0);
        compare_value("cursor_right", int'(cursor_right), 0);
        iterate_and_check(0, 0);

        repeat (6) send_key(key_code_t'({1'b0, random_symbol()}));
        iterate_and_check(0, 0);

        repeat (4) begin
            repeat (3) send_key(move_key());
            iterate_and_check(0, 0);
        end

        // Edits in the middle, then the no-op cases at both ends of the text
        repeat (14) begin
            case ($urandom_range(3, 0))
                0, 1: send_key(key_code_t'({1'b0, random_symbol()}));
                2: send_key(key_code_t'({1'b1, 5'b0, ctrl_backspace}));
                default: send_key(move_key());
            endcase
        end
        iterate_and_check(0, 0);
        repeat (symbol_count) send_key(key_code_t'({1'b1, 5'b0, ctrl_left}));
        send_key(key_code_t'({1'b1, 5'b0, ctrl_backspace}));
        iterate_and_check(0, 0);
        repeat (symbol_count + 1) send_key(key_code_t'({1'b1, 5'b0, ctrl_right}));
        iterate_and_check(0, 0);

        // At least three inserts land on a full buffer
        repeat (symbol_count + 3) send_key(key_code_t'({1'b0, random_symbol()}));
        iterate_and_check(0, 0);

        iterate_and_check(4, 3);
        iterate_and_check(9, 1);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== text_editor.f ====
text_edit_pkg.sv
key_decoder.sv
symbol_cell.sv
symbol_vector.sv
text_buffer.sv
text_editor_top.sv
tb_clock_gen.sv
tb_text_editor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the text editor testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_text_editor -f text_editor.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_text_editor > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
